/* design/asg_data_pkg.sv */
/*
 * datapath types of the signal generator
 * sample width, fixed-point pointer widths and the pointer type
 */

package asg_data_pkg;

  localparam int unsigned DW  = 14;  // sample width
  localparam int unsigned CWM = 14;  // pointer integer bits, table is 2^CWM words
  localparam int unsigned CWF = 16;  // pointer fraction bits

  // one signed output sample
  typedef logic signed [DW-1:0] sample_t;

  // unsigned fixed point, CWM.CWF
  typedef logic [CWM+CWF-1:0] ptr_t;

endpackage : asg_data_pkg

/* design/asg_regs_pkg.sv */
/*
 * register map of the signal generator
 * byte offsets, table window select bit and the configuration struct
 */

package asg_regs_pkg;

  localparam int unsigned TN = 4;  // external trigger lines

  localparam logic [5:0] REG_CTL = 6'h00;  // bit 0 reset, bit 1 sw trigger
  localparam logic [5:0] REG_TRG = 6'h04;  // external trigger mask
  localparam logic [5:0] REG_STS = 6'h08;  // armed, running (ro)
  localparam logic [5:0] REG_SIZ = 6'h10;  // table size
  localparam logic [5:0] REG_OFF = 6'h14;  // start offset (phase)
  localparam logic [5:0] REG_STP = 6'h18;  // step (frequency)
  localparam logic [5:0] REG_BMD = 6'h20;  // burst enable, infinite
  localparam logic [5:0] REG_BDL = 6'h24;  // samples per burst
  localparam logic [5:0] REG_BLN = 6'h28;  // idle cycles between bursts
  localparam logic [5:0] REG_BNM = 6'h2c;  // number of bursts
  localparam logic [5:0] REG_MUL = 6'h30;  // gain
  localparam logic [5:0] REG_SUM = 6'h34;  // offset

  localparam int unsigned BUF_SEL_BIT = 16;  // set -> table window

  typedef struct packed {
    logic [TN-1:0]                   trg;
    asg_data_pkg::ptr_t              siz;
    asg_data_pkg::ptr_t              off;
    asg_data_pkg::ptr_t              stp;
    logic                            ben;
    logic                            inf;
    logic [asg_data_pkg::CWM-1:0]    bdl;
    logic [31:0]                     bln;
    logic [15:0]                     bnm;
    asg_data_pkg::sample_t           mul;
    asg_data_pkg::sample_t           sum;
  } asg_cfg_t;

endpackage : asg_regs_pkg

/* design/sample_stream_if.sv */
/*
 * valid/ready sample stream with last flag
 * payload type is a parameter, src and snk modports
 */

interface sample_stream_if #(
  parameter type dat_t = asg_data_pkg::sample_t
);

  logic valid;  // beat present
  logic ready;  // sink can take it
  dat_t data;
  logic last;   // final beat of a burst

  modport src (output valid, output data, output last, input ready);
  modport snk (input valid, input data, input last, output ready);

endinterface : sample_stream_if

/* design/asg_regs.sv */
/*
 * AXI4-Lite slave with one outstanding access per direction
 * configuration registers, control strobes and table window routing
 */

module asg_regs #(
  parameter int unsigned DW = asg_data_pkg::DW,
  parameter int unsigned TN = asg_regs_pkg::TN
) (
  input  logic                         bus_clk,
  input  logic                         arst_n,
  // AXI4-Lite
  input  logic                         aw_valid,
  output logic                         aw_ready,
  input  logic [16:0]                  aw_addr,
  input  logic                         w_valid,
  output logic                         w_ready,
  input  logic [31:0]                  w_data,
  output logic                         b_valid,
  input  logic                         b_ready,
  output logic [1:0]                   b_resp,
  input  logic                         ar_valid,
  output logic                         ar_ready,
  input  logic [16:0]                  ar_addr,
  output logic                         r_valid,
  input  logic                         r_ready,
  output logic [31:0]                  r_data,
  output logic [1:0]                   r_resp,
  // engine side
  output asg_regs_pkg::asg_cfg_t       cfg,
  output logic                         ctl_rst,
  output logic                         ctl_trg,
  input  logic                         sts_armed,
  input  logic                         sts_running,
  // table bus port
  output logic                         bwe,
  output logic [asg_data_pkg::CWM-1:0] baddr,
  output asg_data_pkg::sample_t        bwdata,
  input  asg_data_pkg::sample_t        brdata
);

  localparam int unsigned PW  = $bits(asg_data_pkg::ptr_t);
  localparam int unsigned SEL = asg_regs_pkg::BUF_SEL_BIT;

  logic        wr_acc, rd_acc;
  logic        wr_reg;   // write hits the register file
  logic        rd_stg;   // read waiting on table latency
  logic        rd_buf;   // that read targets the table
  logic [31:0] rd_reg;   // register readback, held for stage 2

  ////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////

  assign rd_acc = ar_valid & ~rd_stg & ~r_valid;
  // a table read and a table write share baddr, read wins that cycle
  assign wr_acc = aw_valid & w_valid & ~b_valid & ~(rd_acc & ar_addr[SEL] & aw_addr[SEL]);
  assign wr_reg = wr_acc & ~aw_addr[SEL];

  assign aw_ready = wr_acc;
  assign w_ready  = wr_acc;
  assign ar_ready = rd_acc;
  assign b_resp   = 2'b00;  // always OKAY
  assign r_resp   = 2'b00;

  // table port routing
  assign bwe    = wr_acc & aw_addr[SEL];
  assign baddr  = rd_acc ? ar_addr[2 +: asg_data_pkg::CWM] : aw_addr[2 +: asg_data_pkg::CWM];
  assign bwdata = w_data[DW-1:0];

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      b_valid <= 1'b0;
      r_valid <= 1'b0;
      rd_stg  <= 1'b0;
      ctl_rst <= 1'b0;
      ctl_trg <= 1'b0;
    end else begin
      if (wr_acc)       b_valid <= 1'b1;
      else if (b_ready) b_valid <= 1'b0;
      rd_stg <= rd_acc;
      if (rd_stg)       r_valid <= 1'b1;
      else if (r_ready) r_valid <= 1'b0;
      // self clearing strobes
      ctl_rst <= wr_reg & (aw_addr[5:0] == asg_regs_pkg::REG_CTL) & w_data[0];
      ctl_trg <= wr_reg & (aw_addr[5:0] == asg_regs_pkg::REG_CTL) & w_data[1];
    end
  end

  ////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg     <= '0;
      cfg.mul <= asg_data_pkg::sample_t'(1 << (DW-2));  // unit gain
    end else if (wr_reg) begin
      case (aw_addr[5:0])
        asg_regs_pkg::REG_TRG: cfg.trg <= w_data[TN-1:0];
        asg_regs_pkg::REG_SIZ: cfg.siz <= w_data[PW-1:0];
        asg_regs_pkg::REG_OFF: cfg.off <= w_data[PW-1:0];
        asg_regs_pkg::REG_STP: cfg.stp <= w_data[PW-1:0];
        asg_regs_pkg::REG_BMD: begin
          cfg.ben <= w_data[0];
          cfg.inf <= w_data[1];
        end
        asg_regs_pkg::REG_BDL: cfg.bdl <= w_data[asg_data_pkg::CWM-1:0];
        asg_regs_pkg::REG_BLN: cfg.bln <= w_data;
        asg_regs_pkg::REG_BNM: cfg.bnm <= w_data[15:0];
        asg_regs_pkg::REG_MUL: cfg.mul <= w_data[DW-1:0];
        asg_regs_pkg::REG_SUM: cfg.sum <= w_data[DW-1:0];
        default: ;  // CTL and STS hold no state
      endcase
    end
  end

  // read data path, register value taken at accept, table after latency
  always_ff @(posedge bus_clk) begin
    if (rd_acc) begin
      rd_buf <= ar_addr[SEL];
      case (ar_addr[5:0])
        asg_regs_pkg::REG_TRG: rd_reg <= 32'(cfg.trg);
        asg_regs_pkg::REG_STS: rd_reg <= {30'd0, sts_running, sts_armed};
        asg_regs_pkg::REG_SIZ: rd_reg <= 32'(cfg.siz);
        asg_regs_pkg::REG_OFF: rd_reg <= 32'(cfg.off);
        asg_regs_pkg::REG_STP: rd_reg <= 32'(cfg.stp);
        asg_regs_pkg::REG_BMD: rd_reg <= {30'd0, cfg.inf, cfg.ben};
        asg_regs_pkg::REG_BDL: rd_reg <= 32'(cfg.bdl);
        asg_regs_pkg::REG_BLN: rd_reg <= cfg.bln;
        asg_regs_pkg::REG_BNM: rd_reg <= 32'(cfg.bnm);
        asg_regs_pkg::REG_MUL: rd_reg <= {{(32-DW){cfg.mul[DW-1]}}, cfg.mul};
        asg_regs_pkg::REG_SUM: rd_reg <= {{(32-DW){cfg.sum[DW-1]}}, cfg.sum};
        default:               rd_reg <= '0;
      endcase
    end
    if (rd_stg) r_data <= rd_buf ? {{(32-DW){brdata[DW-1]}}, brdata} : rd_reg;
  end

  a_b_hold: assert property (@(posedge bus_clk) disable iff (!arst_n)
    b_valid && !b_ready |=> b_valid);
  a_r_hold: assert property (@(posedge bus_clk) disable iff (!arst_n)
    r_valid && !r_ready |=> r_valid && $stable(r_data));
  a_rst_pulse: assert property (@(posedge bus_clk) disable iff (!arst_n)
    ctl_rst |=> !ctl_rst);
  a_trg_pulse: assert property (@(posedge bus_clk) disable iff (!arst_n)
    ctl_trg |=> !ctl_trg);

endmodule : asg_regs

/* design/asg_buffer.sv */
/*
 * sample table, 2^CWM words
 * bus port (write/read) and engine read port, both synchronous
 */

module asg_buffer #(
  parameter int unsigned DW  = asg_data_pkg::DW,
  parameter int unsigned CWM = asg_data_pkg::CWM
) (
  input  logic                  bus_clk,
  // software port
  input  logic                  bwe,
  input  logic [CWM-1:0]        baddr,
  input  asg_data_pkg::sample_t bwdata,
  output asg_data_pkg::sample_t brdata,
  // engine port
  input  logic                  ren,
  input  logic [CWM-1:0]        raddr,
  output asg_data_pkg::sample_t rdata
);

  logic [DW-1:0] mem [2**CWM];

  always_ff @(posedge bus_clk) begin
    if (bwe) mem[baddr] <= bwdata;
    brdata <= mem[baddr];  // old data on a write cycle
  end

  // output holds while ren is low, the engine relies on it under stall
  always_ff @(posedge bus_clk) begin
    if (ren) rdata <= mem[raddr];
  end

endmodule : asg_buffer

/* design/asg_engine.sv */
/*
 * generator engine
 * trigger arming and edge detect, fixed-point pointer stepping,
 * burst FSM and the raw sample stream out of the table
 */

module asg_engine #(
  parameter int unsigned TN  = asg_regs_pkg::TN,
  parameter int unsigned CWM = asg_data_pkg::CWM,
  parameter int unsigned CWF = asg_data_pkg::CWF
) (
  input  logic                   bus_clk,
  input  logic                   arst_n,
  input  asg_regs_pkg::asg_cfg_t cfg,
  input  logic                   ctl_rst,
  input  logic                   ctl_trg,
  input  logic [TN-1:0]          trg_ext,
  // table read port
  output logic [CWM-1:0]         raddr,
  output logic                   ren,
  input  asg_data_pkg::sample_t  rdata,
  sample_stream_if.src           raw,
  output logic                   irq_trg,
  output logic                   irq_stp,
  output logic                   sts_armed,
  output logic                   sts_running
);

  typedef enum logic [1:0] {ST_IDLE, ST_ARMED, ST_RUN, ST_GAP} state_t;

  state_t             state;
  asg_data_pkg::ptr_t ptr, ptr_nxt;
  logic [CWM+CWF:0]   ptr_sum;   // one guard bit
  logic [TN-1:0]      trg_d;
  logic               trg;
  logic               rd_go;     // read issued this cycle
  logic               vld, lst;
  logic [CWM-1:0]     bcnt;      // beats in current burst
  logic [15:0]        ncnt;      // bursts done
  logic [31:0]        gcnt;      // gap cycles left
  logic               bst_end, run_end;

  assign trg = ctl_trg | (|(trg_ext & ~trg_d & cfg.trg));  // rising edges only

  // step, then wrap by table size
  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg.stp};
  assign ptr_nxt = (ptr_sum >= {1'b0, cfg.siz}) ? ptr_sum[CWM+CWF-1:0] - cfg.siz
                                                : ptr_sum[CWM+CWF-1:0];

  assign bst_end = cfg.ben & (bcnt == cfg.bdl - 1'b1);
  assign run_end = bst_end & ~cfg.inf & (ncnt == cfg.bnm - 1'b1);

  // read only into an empty or draining output
  assign rd_go = (state == ST_RUN) & (~vld | raw.ready);
  assign ren   = rd_go;
  assign raddr = ptr[CWF +: CWM];  // integer part

  assign raw.valid = vld;
  assign raw.data  = rdata;
  assign raw.last  = lst;

  assign sts_armed   = (state == ST_ARMED);
  assign sts_running = (state == ST_RUN) | (state == ST_GAP) | vld;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      ptr     <= '0;
      trg_d   <= '0;
      vld     <= 1'b0;
      lst     <= 1'b0;
      bcnt    <= '0;
      ncnt    <= '0;
      gcnt    <= '0;
      irq_trg <= 1'b0;
      irq_stp <= 1'b0;
    end else begin
      trg_d   <= trg_ext;
      irq_trg <= 1'b0;
      irq_stp <= (state == ST_IDLE) & vld & raw.ready;  // final beat gone
      if (raw.ready) vld <= 1'b0;
      if (rd_go) begin
        vld <= 1'b1;
        lst <= bst_end;
      end
      if (ctl_rst) begin
        state <= ST_ARMED;
        vld   <= 1'b0;
      end else begin
        case (state)
          ST_ARMED: if (trg) begin
            state   <= ST_RUN;
            irq_trg <= 1'b1;
            ptr     <= cfg.off;
            bcnt    <= '0;
            ncnt    <= '0;
          end
          ST_RUN: if (rd_go) begin
            if (bst_end) begin
              bcnt <= '0;
              ncnt <= ncnt + 1'b1;
              ptr  <= cfg.off;  // next burst restarts at phase
              if (run_end) begin
                state <= ST_IDLE;
              end else if (cfg.bln != '0) begin
                state <= ST_GAP;
                gcnt  <= cfg.bln - 1'b1;
              end
            end else begin
              bcnt <= bcnt + 1'b1;
              ptr  <= ptr_nxt;
            end
          end
          ST_GAP: begin
            gcnt <= gcnt - 1'b1;
            if (gcnt == '0) state <= ST_RUN;
          end
          default: ;  // idle waits for ctl_rst
        endcase
      end
    end
  end

  // holds because the table output only moves with ren
  a_raw_hold: assert property (@(posedge bus_clk) disable iff (!arst_n)
    raw.valid && !raw.ready && !ctl_rst |=>
      raw.valid && $stable(raw.data) && $stable(raw.last));

endmodule : asg_engine

/* design/asg_linear.sv */
/*
 * gain and offset stage on the sample stream
 * (x * mul) >>> (DW-2) + sum, saturated, one register
 */

module asg_linear #(
  parameter int unsigned DW = asg_data_pkg::DW
) (
  input  logic                  bus_clk,
  input  logic                  arst_n,
  input  asg_data_pkg::sample_t cfg_mul,  // 2^(DW-2) is unity
  input  asg_data_pkg::sample_t cfg_sum,
  sample_stream_if.snk          raw,
  sample_stream_if.src          out
);

  logic signed [2*DW-1:0] prd;
  logic signed [DW+1:0]   scl, sum;  // two guard bits
  logic [DW-1:0]          sat;
  logic                   vld, lst;
  logic [DW-1:0]          dat;

  assign prd = raw.data * cfg_mul;
  assign scl = (DW+2)'(prd >>> (DW-2));
  assign sum = scl + cfg_sum;

  // clip when the guard bits disagree with the sign
  assign sat = (sum[DW+1:DW-1] == '0 || sum[DW+1:DW-1] == '1) ? sum[DW-1:0] :
               sum[DW+1] ? {1'b1, {(DW-1){1'b0}}} : {1'b0, {(DW-1){1'b1}}};

  assign raw.ready = ~vld | out.ready;  // empty or draining
  assign out.valid = vld;
  assign out.data  = dat;
  assign out.last  = lst;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n)        vld <= 1'b0;
    else if (raw.ready) vld <= raw.valid;
  end

  always_ff @(posedge bus_clk) begin
    if (raw.valid && raw.ready) begin
      dat <= sat;
      lst <= raw.last;
    end
  end

endmodule : asg_linear

/* design/asg_top.sv */
/*
 * signal generator top level
 * AXI4-Lite registers, sample table, engine and gain/offset stage
 */

module asg_top #(
  parameter int unsigned DW  = asg_data_pkg::DW,
  parameter int unsigned TN  = asg_regs_pkg::TN,
  parameter int unsigned CWM = asg_data_pkg::CWM,
  parameter int unsigned CWF = asg_data_pkg::CWF
) (
  input  logic                  bus_clk,
  input  logic                  arst_n,
  // AXI4-Lite slave
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  logic [16:0]           aw_addr,
  input  logic                  w_valid,
  output logic                  w_ready,
  input  logic [31:0]           w_data,
  output logic                  b_valid,
  input  logic                  b_ready,
  output logic [1:0]            b_resp,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  input  logic [16:0]           ar_addr,
  output logic                  r_valid,
  input  logic                  r_ready,
  output logic [31:0]           r_data,
  output logic [1:0]            r_resp,
  // triggers and interrupts
  input  logic [TN-1:0]         trg_ext,
  output logic                  irq_trg,
  output logic                  irq_stp,
  // sample stream out
  output logic                  str_valid,
  input  logic                  str_ready,
  output asg_data_pkg::sample_t str_data,
  output logic                  str_last
);

  asg_regs_pkg::asg_cfg_t cfg;
  logic                   ctl_rst, ctl_trg, sts_armed, sts_running;
  logic                   bwe, ren;
  logic [CWM-1:0]         baddr, raddr;
  asg_data_pkg::sample_t  bwdata, brdata, rdata;

  sample_stream_if #(.dat_t(asg_data_pkg::sample_t)) raw ();  // engine -> linear
  sample_stream_if #(.dat_t(asg_data_pkg::sample_t)) out ();  // linear -> ports

  assign str_valid = out.valid;
  assign str_data  = out.data;
  assign str_last  = out.last;
  assign out.ready = str_ready;

  asg_regs #(.DW(DW), .TN(TN)) u_regs (
    .bus_clk, .arst_n,
    .aw_valid, .aw_ready, .aw_addr, .w_valid, .w_ready, .w_data,
    .b_valid, .b_ready, .b_resp,
    .ar_valid, .ar_ready, .ar_addr, .r_valid, .r_ready, .r_data, .r_resp,
    .cfg, .ctl_rst, .ctl_trg, .sts_armed, .sts_running,
    .bwe, .baddr, .bwdata, .brdata
  );

  asg_buffer #(.DW(DW), .CWM(CWM)) u_buffer (
    .bus_clk, .bwe, .baddr, .bwdata, .brdata, .ren, .raddr, .rdata
  );

  asg_engine #(.TN(TN), .CWM(CWM), .CWF(CWF)) u_engine (
    .bus_clk, .arst_n, .cfg, .ctl_rst, .ctl_trg, .trg_ext,
    .raddr, .ren, .rdata, .raw(raw.src),
    .irq_trg, .irq_stp, .sts_armed, .sts_running
  );

  asg_linear #(.DW(DW)) u_linear (
    .bus_clk, .arst_n, .cfg_mul(cfg.mul), .cfg_sum(cfg.sum),
    .raw(raw.snk), .out(out.src)
  );

endmodule : asg_top

/* verif/asg_model.svh */
/*
 * reference model of the generator datapath
 * pointer step and wrap, burst sequence, gain/offset with clipping
 */

`ifndef ASG_MODEL_SVH
`define ASG_MODEL_SVH

// pointer after one beat, wrapped once by the table size
function automatic longint step_pointer(input longint ptr, input longint stp, input longint siz);
  longint nxt;
  nxt = ptr + stp;
  if (nxt >= siz) nxt = nxt - siz;
  return nxt;
endfunction

// sample * gain / 2^(DW-2) + offset, clipped to the signed sample range
function automatic int scale_sample(input int x, input int mul, input int sum);
  longint acc;
  longint hi;
  longint lo;
  hi  = (longint'(1) << (asg_data_pkg::DW - 1)) - 1;
  lo  = -(longint'(1) << (asg_data_pkg::DW - 1));
  acc = (longint'(x) * mul) >>> (asg_data_pkg::DW - 2);  // rounds toward -inf
  acc = acc + sum;
  if (acc > hi) acc = hi;
  if (acc < lo) acc = lo;
  return int'(acc);
endfunction

// queue the expected output beats of one run into exp_dat / exp_lst
// continuous: nbeats beats, burst: bnm bursts of bdl beats
task automatic queue_expected(input longint siz, input longint off, input longint stp,
                              input bit ben, input int bdl, input int bnm, input int nbeats,
                              input int mul, input int sum);
  longint ptr;
  int     nrun;
  int     len;
  int     b;
  int     k;
  nrun = ben ? bnm : 1;
  len  = ben ? bdl : nbeats;
  for (b = 0; b < nrun; b++) begin
    ptr = off;  // every burst restarts at the phase
    for (k = 0; k < len; k++) begin
      // table lookup at the integer part of the pointer
      exp_dat.push_back(scale_sample(tbl[int'(ptr >> asg_data_pkg::CWF)], mul, sum));
      exp_lst.push_back(ben && (k == len - 1));
      ptr = step_pointer(ptr, stp, siz);
    end
  end
endtask

`endif

/* verif/asg_tb.sv */
/*
 * testbench of the signal generator
 * clock, reset, LCG, AXI4-Lite tasks, stream monitor and checks
 * register, table, wrap, gain, burst and back-pressure tests
 */

module asg_tb;

  localparam int DW      = asg_data_pkg::DW;
  localparam int CWM     = asg_data_pkg::CWM;
  localparam int CWF     = asg_data_pkg::CWF;
  localparam int TN      = asg_regs_pkg::TN;
  localparam int BEATS   = 64;  // per continuous run
  localparam int MAX_BDL = 8;
  localparam int MAX_BNM = 4;
  localparam int MAX_BLN = 11;
  // 20x all stream beats and burst gaps, bus traffic sits in the margin
  localparam int LIMIT = 20 * (3 * BEATS + MAX_BDL * MAX_BNM + MAX_BNM * MAX_BLN);
  localparam int UNIT  = 1 << (DW - 2);  // unit gain

  logic                  bus_clk, arst_n;
  logic                  aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic                  ar_valid, ar_ready, r_valid, r_ready;
  logic [16:0]           aw_addr, ar_addr;
  logic [31:0]           w_data, r_data;
  logic [1:0]            b_resp, r_resp;
  logic [TN-1:0]         trg_ext;
  logic                  irq_trg, irq_stp;
  logic                  str_valid, str_ready, str_last;
  asg_data_pkg::sample_t str_data;

  logic [31:0] seed = 32'd34;
  int          cyc = 0;
  int          errs = 0;
  int          ntests = 0;
  int          err_mark;
  string       tname;
  int          tbl [int];  // shadow of the sample table
  int          exp_dat [$];
  bit          exp_lst [$];
  bit          mon_en = 0, extra_chk = 0, gap_chk = 0, after_last;
  int          trg_cnt, stp_cnt, trg_cyc, first_cyc, last_cyc;
  int          wr_cyc;  // cycle of the last write accept
  logic [31:0] c_siz, c_off, c_stp, c_bln;  // config of the current run
  logic        c_ben;
  logic [TN-1:0] c_trg;
  int          c_bdl, c_bnm, c_mul, c_sum;

  `include "asg_model.svh"

  asg_top dut (.*);

  initial begin
    bus_clk = 1'b0;
    forever #50 bus_clk = ~bus_clk;
  end

  always @(posedge bus_clk) cyc++;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rnd(input int n);  // 0..n-1, upper bits only
    logic [31:0] r;
    r = lcg();
    return int'(r[31:8] % n);
  endfunction

  function automatic int rnd_sample();
    logic [31:0] r;
    r = lcg();
    return int'($signed(r[31:18]));
  endfunction

  function automatic logic [16:0] reg_addr(input logic [5:0] off);
    return {11'd0, off};
  endfunction

  function automatic logic [16:0] tbl_addr(input int a);
    return {1'b1, CWM'(a), 2'b00};  // window bit, word address
  endfunction

  // readback of a written value, masked to the field width
  function automatic logic [31:0] reg_expect(input logic [5:0] off, input logic [31:0] v);
    case (off)
      asg_regs_pkg::REG_TRG: return v & 32'hf;
      asg_regs_pkg::REG_SIZ, asg_regs_pkg::REG_OFF,
      asg_regs_pkg::REG_STP: return v & 32'h3fff_ffff;
      asg_regs_pkg::REG_BMD: return v & 32'h3;
      asg_regs_pkg::REG_BDL: return v & 32'h3fff;
      asg_regs_pkg::REG_BNM: return v & 32'hffff;
      asg_regs_pkg::REG_MUL, asg_regs_pkg::REG_SUM: return {{18{v[13]}}, v[13:0]};
      default: return v;  // BLN
    endcase
  endfunction

  task automatic check_value(input string name, input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
    if (expected !== actual) begin
      errs++;
      $display("ERROR [%s] %s: expected %0d, actual %0d", tname, name, expected, actual);
    end
  endtask

  task automatic next_cycle();
    @(posedge bus_clk);
    #10;
  endtask

  task automatic test_begin(input string name);
    tname    = name;
    err_mark = errs;
  endtask

  task automatic test_end();
    ntests++;
    $display("test %s: %0d errors", tname, errs - err_mark);
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite, b_ready and r_ready stay high
  ////////////////////////////////////////////////////////////

  task automatic bus_write(input logic [16:0] addr, input logic [31:0] data);
    aw_addr  = addr;
    w_data   = data;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    @(negedge bus_clk);
    while (!(aw_ready || w_ready)) @(negedge bus_clk);
    check_value("aw_ready", 1, aw_ready);  // both pulse together
    check_value("w_ready", 1, w_ready);
    wr_cyc = cyc;
    next_cycle();
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    @(negedge bus_clk);
    while (!b_valid) @(negedge bus_clk);
    check_value("bresp", 0, b_resp);
    next_cycle();
  endtask

  task automatic bus_read(input logic [16:0] addr, output logic [31:0] data);
    ar_addr  = addr;
    ar_valid = 1'b1;
    @(negedge bus_clk);
    while (!ar_ready) @(negedge bus_clk);
    next_cycle();
    ar_valid = 1'b0;
    @(negedge bus_clk);
    while (!r_valid) @(negedge bus_clk);
    check_value("rresp", 0, r_resp);
    data = r_data;
    next_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // stream runs
  ////////////////////////////////////////////////////////////

  task automatic pick_pointer();
    c_siz = ((8 + rnd(56)) << CWF) | rnd(1 << CWF);  // below 64.0
    c_off = lcg() % c_siz;
    c_stp = 1 + rnd(4 << CWF);  // nonzero, up to 4.0
  endtask

  task automatic program_cfg();
    bus_write(reg_addr(asg_regs_pkg::REG_TRG), 32'(c_trg));
    bus_write(reg_addr(asg_regs_pkg::REG_SIZ), c_siz);
    bus_write(reg_addr(asg_regs_pkg::REG_OFF), c_off);
    bus_write(reg_addr(asg_regs_pkg::REG_STP), c_stp);
    bus_write(reg_addr(asg_regs_pkg::REG_BMD), {31'd0, c_ben});
    bus_write(reg_addr(asg_regs_pkg::REG_BDL), 32'(c_bdl));
    bus_write(reg_addr(asg_regs_pkg::REG_BLN), c_bln);
    bus_write(reg_addr(asg_regs_pkg::REG_BNM), 32'(c_bnm));
    bus_write(reg_addr(asg_regs_pkg::REG_MUL), 32'(c_mul));
    bus_write(reg_addr(asg_regs_pkg::REG_SUM), 32'(c_sum));
    bus_write(reg_addr(asg_regs_pkg::REG_CTL), 32'd1);  // arm
  endtask

  task automatic arm_monitor(input bit extra, input bit gap);
    trg_cnt    = 0;
    stp_cnt    = 0;
    trg_cyc    = -1;
    first_cyc  = -1;
    after_last = 0;
    extra_chk  = extra;
    gap_chk    = gap;
    mon_en     = 1'b1;
  endtask

  task automatic drain(input bit random_ready);
    while (exp_dat.size() != 0) begin
      next_cycle();
      str_ready = random_ready ? (rnd(2) != 0) : 1'b1;
    end
  endtask

  task automatic stop_engine();
    mon_en    = 1'b0;
    str_ready = 1'b1;
    bus_write(reg_addr(asg_regs_pkg::REG_CTL), 32'd1);  // back to armed
    repeat (3) next_cycle();  // linear register empties
  endtask

  // software trigger, wrapping forever, first BEATS beats compared
  task automatic run_wrap(input bit random_ready);
    c_ben = 1'b0;
    c_bdl = 0;
    c_bln = 0;
    c_bnm = 0;
    c_trg = '0;
    program_cfg();
    queue_expected(c_siz, c_off, c_stp, 1'b0, 0, 0, BEATS, c_mul, c_sum);
    arm_monitor(1'b0, 1'b0);
    bus_write(reg_addr(asg_regs_pkg::REG_CTL), 32'd2);
    drain(random_ready);
    check_value("irq_trg pulses", 1, trg_cnt);
    // strobe runs the cycle after the accept, irq_trg one later
    check_value("irq_trg cycle", wr_cyc + 2, trg_cyc);
    check_value("first beat latency", 3, first_cyc - (wr_cyc + 1));
    stop_engine();
  endtask

  ////////////////////////////////////////////////////////////
  // monitor, outputs sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge bus_clk) begin : monitor
    int e_dat;
    bit e_lst;
    if (mon_en) begin
      if (irq_trg) begin
        trg_cnt++;
        trg_cyc = cyc;
      end
      if (irq_stp) stp_cnt++;
      if (str_valid && first_cyc < 0) first_cyc = cyc;
      if (str_valid && str_ready) begin
        if (exp_dat.size() != 0) begin
          e_dat = exp_dat.pop_front();
          e_lst = exp_lst.pop_front();
          check_value("beat data", e_dat, str_data);
          check_value("beat last", e_lst, str_last);
          if (gap_chk && after_last) check_value("burst gap", c_bln + 1, cyc - last_cyc);
          after_last = e_lst;
          last_cyc   = cyc;
        end else if (extra_chk) begin
          errs++;
          $display("test %s: output beat after the run should have ended", tname);
        end
      end
    end
  end

  initial begin : watchdog
    while (cyc < LIMIT) @(negedge bus_clk);
    $display("timeout: run still busy after %0d cycles", cyc);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] rd, wv, s_siz, s_off, s_stp;
    logic [5:0]  offs [10];
    int          addrs [32];
    int          a, k, j;
    arst_n    = 1'b0;
    aw_valid  = 1'b0;
    w_valid   = 1'b0;
    ar_valid  = 1'b0;
    b_ready   = 1'b1;
    r_ready   = 1'b1;
    aw_addr   = '0;
    ar_addr   = '0;
    w_data    = '0;
    trg_ext   = '0;
    str_ready = 1'b1;
    repeat (4) @(posedge bus_clk);
    #10 arst_n = 1'b1;
    next_cycle();

    test_begin("regs");
    bus_read(reg_addr(asg_regs_pkg::REG_MUL), rd);
    check_value("mul after reset", UNIT, rd);
    bus_read(reg_addr(asg_regs_pkg::REG_STS), rd);
    check_value("status after reset", 0, rd);
    offs = '{asg_regs_pkg::REG_TRG, asg_regs_pkg::REG_SIZ, asg_regs_pkg::REG_OFF,
             asg_regs_pkg::REG_STP, asg_regs_pkg::REG_BMD, asg_regs_pkg::REG_BDL,
             asg_regs_pkg::REG_BLN, asg_regs_pkg::REG_BNM, asg_regs_pkg::REG_MUL,
             asg_regs_pkg::REG_SUM};
    for (k = 0; k < 10; k++) begin
      wv = lcg();
      bus_write(reg_addr(offs[k]), wv);
      bus_read(reg_addr(offs[k]), rd);
      check_value($sformatf("reg 0x%02h", offs[k]), reg_expect(offs[k], wv), rd);
    end
    test_end();

    test_begin("table");
    for (k = 0; k < 32; k++) begin
      addrs[k]      = rnd(1 << CWM);
      tbl[addrs[k]] = rnd_sample();
      bus_write(tbl_addr(addrs[k]), 32'(tbl[addrs[k]]));
    end
    for (k = 0; k < 32; k++) begin
      bus_read(tbl_addr(addrs[k]), rd);
      check_value("table word", tbl[addrs[k]], $signed(rd[DW-1:0]));
    end
    test_end();

    for (a = 0; a < 64; a++) begin  // every word a run can reach
      tbl[a] = rnd_sample();
      bus_write(tbl_addr(a), 32'(tbl[a]));
    end

    test_begin("wrap");
    pick_pointer();
    s_siz = c_siz;
    s_off = c_off;
    s_stp = c_stp;
    c_mul = UNIT;
    c_sum = 0;
    run_wrap(1'b0);
    test_end();

    test_begin("gain");
    pick_pointer();
    c_mul = UNIT + rnd(UNIT);  // gain 1.0 to 2.0, either sign
    if (rnd(2) != 0) c_mul = -c_mul;
    c_sum = UNIT + rnd(UNIT);  // large offset pushes beats into the rails
    if (rnd(2) != 0) c_sum = -c_sum;
    run_wrap(1'b0);
    test_end();

    test_begin("burst");
    pick_pointer();
    c_ben = 1'b1;
    c_bdl = 2 + rnd(MAX_BDL - 1);
    c_bnm = 2 + rnd(MAX_BNM - 1);
    c_bln = rnd(MAX_BLN + 1);
    k     = rnd(TN);
    j     = (k + 1 + rnd(TN - 1)) % TN;  // a line outside the mask
    c_trg = TN'(1 << k);
    c_mul = UNIT;
    c_sum = 0;
    program_cfg();
    queue_expected(c_siz, c_off, c_stp, 1'b1, c_bdl, c_bnm, 0, c_mul, c_sum);
    arm_monitor(1'b1, 1'b1);
    trg_ext = TN'(1 << j);
    next_cycle();
    trg_ext = '0;
    repeat (3) next_cycle();
    bus_read(reg_addr(asg_regs_pkg::REG_STS), rd);
    check_value("status after unmasked edge", 1, rd);  // still armed
    check_value("irq_trg before trigger", 0, trg_cnt);
    trg_ext = TN'(1 << k);
    next_cycle();
    trg_ext = '0;
    drain(1'b0);
    repeat (4) next_cycle();  // irq_stp trails the final beat
    check_value("irq_trg pulses", 1, trg_cnt);
    check_value("irq_stp pulses", 1, stp_cnt);
    stop_engine();
    test_end();

    test_begin("backpressure");
    c_siz = s_siz;  // same run as the wrap test
    c_off = s_off;
    c_stp = s_stp;
    c_mul = UNIT;
    c_sum = 0;
    run_wrap(1'b1);
    test_end();

    $display("%0d errors in %0d tests", errs, ntests);
    if (errs == 0) $display("Finished with no errors");
    else $display("Finished with errors");
    $finish;
  end

endmodule : asg_tb

/* asg_top.f */
+incdir+verif
design/asg_data_pkg.sv
design/asg_regs_pkg.sv
design/sample_stream_if.sv
design/asg_regs.sv
design/asg_buffer.sv
design/asg_engine.sv
design/asg_linear.sv
design/asg_top.sv
verif/asg_tb.sv

/* Bender.yml */
package:
  name: asg

sources:
  - files:
      - design/asg_data_pkg.sv
      - design/asg_regs_pkg.sv
      - design/sample_stream_if.sv
      - design/asg_regs.sv
      - design/asg_buffer.sv
      - design/asg_engine.sv
      - design/asg_linear.sv
      - design/asg_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/asg_tb.sv
